// File: sim.f
+incdir+verilog
verilog/ext_mem_pkg.sv
verilog/l1_cache.sv
verilog/bus_merge.sv
verilog/ext_mem_top.sv
testbench/ext_mem_mem_model.sv
testbench/ext_mem_monitor.sv
testbench/ext_mem_checker.sv
testbench/tb_ext_mem.sv

// File: testbench/tb_ext_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module tb_ext_mem;

   import ext_mem_pkg::*;

   logic      clk_i;
   logic      rst_i;
   logic      invalidate;
   nat_req_t  port_req [`EM_NPORTS];
   nat_resp_t port_resp [`EM_NPORTS];
   nat_req_t  mem_req;
   nat_resp_t mem_resp;

   int seed      = 32'hf46d_e663;
   int tb_errors = 0;
   int n_tests   = 0;
   int err_mark, rd_mark, rep_mark;

   ext_mem_top DUT (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .port_req_i   (port_req),
      .port_resp_o  (port_resp),
      .invalidate_i (invalidate),
      .mem_req_o    (mem_req),
      .mem_resp_i   (mem_resp)
   );

   ext_mem_mem_model u_mem (.clk_i(clk_i), .rst_i(rst_i), .req_i(mem_req), .resp_o(mem_resp));

   ext_mem_monitor u_mon (
      .clk_i        (clk_i),
      .port_req_i   (port_req),
      .port_resp_i  (port_resp),
      .invalidate_i (invalidate),
      .mem_req_i    (mem_req),
      .mem_resp_i   (mem_resp)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic int total_errors();
      return tb_errors + u_mon.errors;
   endfunction

   task automatic start_test();
      err_mark = total_errors();
      rd_mark  = u_mon.rd_count;
      rep_mark = u_mon.repeats;
   endtask

   task automatic finish_test(input string name, input bit ok);
      n_tests++;
      if (!ok) tb_errors++;
      if (total_errors() == err_mark) $display("Test %0d %s: pass", n_tests, name);
      else $display("Test %0d %s: FAIL", n_tests, name);
   endtask

   // One access on port p, returns read data and latency in edges
   task automatic access(input int p, input addr_t addr, input data_t wdata,
                         input strb_t wstrb, output data_t rdata, output int cycles);
      int n;
      n = 0;
      @(posedge clk_i);
      port_req[p] <= '{req: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      do begin
         @(negedge clk_i);
         n++;
      end while (!port_resp[p].ack && n < 300);
      if (!port_resp[p].ack) begin
         $display("Timeout: port %0d got no ack for address %h", p, addr);
         $display("ERRORS FOUND");
         $finish;
      end else begin
         rdata  = port_resp[p].rdata;
         cycles = n;
         @(posedge clk_i);
         port_req[p] <= '0;
      end
   endtask

   task automatic pulse_invalidate();
      @(posedge clk_i);
      invalidate <= 1'b1;
      @(posedge clk_i);
      invalidate <= 1'b0;
   endtask

   initial begin
      data_t rd, rd1, old;
      int    cyc, cyc1, r0, r1, n;
      bit    ok;
      rst_i      = 1'b1;
      invalidate = 1'b0;
      for (int p = 0; p < `EM_NPORTS; p++) port_req[p] = '0;
      repeat (16) @(posedge clk_i);
      rst_i <= 1'b0;

      start_test();
      access(0, 16'h0010, '0, '0, rd, cyc);
      access(1, 16'h0050, '0, '0, rd, cyc);
      finish_test("read miss", u_mon.rd_count - rd_mark == 2);

      start_test();
      access(0, 16'h0010, '0, '0, rd, cyc);
      access(1, 16'h0050, '0, '0, rd, cyc1);
      finish_test("read hit", u_mon.rd_count == rd_mark && cyc == 2 && cyc1 == 2);

      start_test();
      access(0, 16'h0010, 32'h1122_3344, 4'b0101, rd, cyc);
      access(0, 16'h0010, '0, '0, rd, cyc); // Cached line, merged
      ok = (u_mon.rd_count == rd_mark);
      access(0, 16'h0020, 32'haabb_ccdd, 4'b1100, rd, cyc);
      access(0, 16'h0020, '0, '0, rd, cyc); // Not allocated on write
      finish_test("partial write", ok && u_mon.rd_count - rd_mark == 1);

      start_test();
      fork
         access(0, 16'h0030, '0, '0, rd, cyc);
         access(1, 16'h0070, '0, '0, rd1, cyc1);
      join
      fork
         access(0, 16'h0031, '0, '0, rd, cyc);
         access(1, 16'h0071, '0, '0, rd1, cyc1);
      join
      finish_test("concurrent ports",
                  u_mon.rd_count - rd_mark == 4 && u_mon.repeats == rep_mark);

      start_test();
      access(1, 16'h0048, '0, '0, old, cyc);
      access(0, 16'h0048, 32'hdead_beef, 4'hf, rd, cyc);
      access(1, 16'h0048, '0, '0, rd, cyc);
      ok = (rd == old); // Stale copy in port 1
      pulse_invalidate();
      access(1, 16'h0048, '0, '0, rd, cyc);
      ok = ok && (rd == 32'hdead_beef);
      fork
         access(1, 16'h0049, '0, '0, rd, cyc);
         begin
            n = 0;
            do begin
               @(negedge clk_i);
               n++;
            end while (!mem_req.req && n < 50);
            if (!mem_req.req) begin
               $display("Timeout: port 1 miss never reached the memory bus");
               $display("ERRORS FOUND");
               $finish;
            end else begin
               pulse_invalidate(); // Lands while the miss is busy
            end
         end
      join
      access(1, 16'h0049, '0, '0, rd, cyc);
      finish_test("invalidate", ok && u_mon.rd_count - rd_mark == 4);

      start_test();
      for (int k = 0; k < 40; k++) begin
         r0 = $random(seed);
         r1 = $random(seed);
         fork
            access(0, addr_t'(r0[5:0]), data_t'($random(seed)),
                   (r0[7:6] == 0) ? ((r0[11:8] == 0) ? 4'hf : r0[11:8]) : 4'h0, rd, cyc);
            access(1, addr_t'(64 + r1[5:0]), data_t'($random(seed)),
                   (r1[7:6] == 0) ? ((r1[11:8] == 0) ? 4'hf : r1[11:8]) : 4'h0, rd1, cyc1);
         join
      end
      finish_test("random mix", 1'b1);

      $display("Summary: %0d tests, %0d testbench check errors, %0d data mismatches",
               n_tests, tb_errors, u_mon.errors);
      if (total_errors() == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/ext_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module ext_mem_checker (
   input logic                   clk_i,
   input logic                   rst_i,
   input ext_mem_pkg::nat_req_t  port_req_i [`EM_NPORTS],
   input ext_mem_pkg::nat_resp_t port_resp_o [`EM_NPORTS],
   input ext_mem_pkg::nat_req_t  mem_req_o,
   input ext_mem_pkg::nat_resp_t mem_resp_i
);

   import ext_mem_pkg::*;

   for (genvar g = 0; g < `EM_NPORTS; g++) begin : g_port
      a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
         port_resp_o[g].ack |=> !port_resp_o[g].ack)
         else $error("Port ack held for more than one cycle");
      a_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
         port_resp_o[g].ack |-> port_req_i[g].req)
         else $error("Port ack without a request");
      a_no_ack_rst: assert property (@(posedge clk_i) rst_i |-> !port_resp_o[g].ack)
         else $error("Port ack during reset");
   end

   a_mem_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_resp_i.ack |=> !mem_resp_i.ack)
      else $error("Memory ack held for more than one cycle");
   a_mem_ack_req: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_resp_i.ack |-> mem_req_o.req)
      else $error("Memory ack without a request");
   // Waiting request keeps its fields
   a_mem_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_req_o.req && !mem_resp_i.ack |=> mem_req_o.req && $stable(mem_req_o.addr)
         && $stable(mem_req_o.wdata) && $stable(mem_req_o.wstrb))
      else $error("Memory request changed before ack");

endmodule

bind ext_mem_top ext_mem_checker u_chk (.*);

`default_nettype wire

// File: testbench/ext_mem_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module ext_mem_monitor (
   input logic                   clk_i,
   input ext_mem_pkg::nat_req_t  port_req_i [`EM_NPORTS],
   input ext_mem_pkg::nat_resp_t port_resp_i [`EM_NPORTS],
   input logic                   invalidate_i,
   input ext_mem_pkg::nat_req_t  mem_req_i,
   input ext_mem_pkg::nat_resp_t mem_resp_i
);

   import ext_mem_pkg::*;

   localparam int N_LINES = 1 << `EM_IDX_W;

   int    errors    = 0;
   int    rd_count  = 0; // Back-end reads
   int    repeats   = 0; // Back-end reads from the same half twice in a row
   int    last_half = -1;
   data_t shadow [addr_t];
   bit    c_valid [`EM_NPORTS][N_LINES];
   addr_t c_addr [`EM_NPORTS][N_LINES];
   data_t c_data [`EM_NPORTS][N_LINES];
   bit    busy [`EM_NPORTS];
   bit    pend [`EM_NPORTS]; // Invalidation held until the access ends

   function automatic data_t mem_word(input addr_t a);
      if (shadow.exists(a)) begin
         return shadow[a];
      end
      return {a ^ 16'ha5c3, ~a};
   endfunction

   function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t s);
      data_t r;
      r = old;
      for (int b = 0; b < `EM_STRB_W; b++) begin
         if (s[b]) r[8*b +: 8] = wd[8*b +: 8];
      end
      return r;
   endfunction

   function automatic data_t expected_read(input int p, input addr_t a);
      idx_t i;
      i = a[`EM_IDX_W-1:0];
      if (c_valid[p][i] && c_addr[p][i] == a) begin
         return c_data[p][i]; // Hit, possibly stale
      end
      return mem_word(a);
   endfunction

   always @(negedge clk_i) begin
      addr_t a;
      idx_t  i;
      data_t exp_d;
      bit    wr_ok;
      if (mem_req_i.req && mem_resp_i.ack) begin
         a = mem_req_i.addr;
         if (mem_req_i.wstrb != '0) begin
            // Bus write carries a waiting port write unchanged
            wr_ok = 1'b0;
            for (int p = 0; p < `EM_NPORTS; p++) begin
               if (port_req_i[p].req && port_req_i[p].addr == a
                   && port_req_i[p].wdata == mem_req_i.wdata
                   && port_req_i[p].wstrb == mem_req_i.wstrb) begin
                  wr_ok = 1'b1;
               end
            end
            if (!wr_ok) begin
               errors++;
               $display("MISMATCH at %0t: memory write addr %h data %h strobe %h, no such port write",
                        $time, a, mem_req_i.wdata, mem_req_i.wstrb);
            end
         end else begin
            rd_count++;
            if (int'(a[6]) == last_half) repeats++;
            last_half = int'(a[6]);
         end
      end
      for (int p = 0; p < `EM_NPORTS; p++) begin
         a = port_req_i[p].addr;
         i = a[`EM_IDX_W-1:0];
         if (port_resp_i[p].ack) begin
            if (port_req_i[p].wstrb == '0) begin
               exp_d = expected_read(p, a);
               if (port_resp_i[p].rdata !== exp_d) begin
                  errors++;
                  $display("MISMATCH at %0t: port %0d addr %h read %h, expected %h",
                           $time, p, a, port_resp_i[p].rdata, exp_d);
               end
               c_valid[p][i] = 1'b1;
               c_addr[p][i]  = a;
               c_data[p][i]  = exp_d;
            end else begin
               // Write-through, memory takes every port write
               shadow[a] = merge_bytes(mem_word(a), port_req_i[p].wdata,
                                       port_req_i[p].wstrb);
               if (c_valid[p][i] && c_addr[p][i] == a) begin
                  c_data[p][i] = merge_bytes(c_data[p][i], port_req_i[p].wdata,
                                             port_req_i[p].wstrb);
               end
            end
            busy[p] = 1'b0;
         end
         if (invalidate_i || pend[p]) begin
            if (busy[p]) begin
               pend[p] = 1'b1;
            end else begin
               pend[p] = 1'b0;
               for (int k = 0; k < N_LINES; k++) c_valid[p][k] = 1'b0;
            end
         end
         if (!port_resp_i[p].ack && port_req_i[p].req) busy[p] = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: testbench/ext_mem_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module ext_mem_mem_model (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  ext_mem_pkg::nat_req_t  req_i,
   output ext_mem_pkg::nat_resp_t resp_o
);

   import ext_mem_pkg::*;

   localparam int DEPTH = 1 << `EM_ADDR_W;

   int    seed = 32'hf46d_e663;
   int    wait_cnt;
   data_t mem [DEPTH];

   function automatic data_t addr_pattern(input addr_t a);
      return {a ^ 16'ha5c3, ~a};
   endfunction

   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = addr_pattern(addr_t'(i));
      end
   end

   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         resp_o   <= '0;
         wait_cnt <= 0;
      end else if (resp_o.ack) begin
         resp_o.ack <= 1'b0; // Ack lasts one cycle
      end else if (req_i.req) begin
         if (wait_cnt == 0) begin
            wait_cnt <= 1 + (($random(seed) & 32'h7fff_ffff) % 4);
         end else if (wait_cnt == 1) begin
            wait_cnt     <= 0;
            resp_o.ack   <= 1'b1;
            resp_o.rdata <= mem[req_i.addr];
            for (int b = 0; b < `EM_STRB_W; b++) begin
               if (req_i.wstrb[b]) begin
                  mem[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
               end
            end
         end else begin
            wait_cnt <= wait_cnt - 1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/ext_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module ext_mem_top (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  ext_mem_pkg::nat_req_t  port_req_i [`EM_NPORTS],
   output ext_mem_pkg::nat_resp_t port_resp_o [`EM_NPORTS],
   input  logic                  invalidate_i,
   output ext_mem_pkg::nat_req_t  mem_req_o,
   input  ext_mem_pkg::nat_resp_t mem_resp_i
);

   import ext_mem_pkg::*;

   // Cache back-end buses into the merge unit
   nat_req_t  be_req  [`EM_NPORTS];
   nat_resp_t be_resp [`EM_NPORTS];

   for (genvar g = 0; g < `EM_NPORTS; g++) begin : g_l1
      l1_cache u_l1 (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .req_i        (port_req_i[g]),
         .resp_o       (port_resp_o[g]),
         .invalidate_i (invalidate_i), // Shared strobe
         .be_req_o     (be_req[g]),
         .be_resp_i    (be_resp[g])
      );
   end

   bus_merge #(
      .N_PORTS (`EM_NPORTS)
   ) u_merge (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .m_req_i  (be_req),
      .m_resp_o (be_resp),
      .s_req_o  (mem_req_o),
      .s_resp_i (mem_resp_i)
   );

endmodule

`default_nettype wire

// File: verilog/bus_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module bus_merge #(
   parameter int N_PORTS = `EM_NPORTS
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  ext_mem_pkg::nat_req_t  m_req_i [N_PORTS],
   output ext_mem_pkg::nat_resp_t m_resp_o [N_PORTS],
   output ext_mem_pkg::nat_req_t  s_req_o,
   input  ext_mem_pkg::nat_resp_t s_resp_i
);

   import ext_mem_pkg::*;

   localparam int SEL_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

   logic [SEL_W-1:0] grant_q;  // Last granted port
   logic             busy_q;   // Grant locked until ack
   logic [SEL_W-1:0] next_idx;
   logic             found;
   logic [SEL_W-1:0] sel_idx;
   logic             sel_valid;
   nat_req_t         sel_req;

   // Round-robin search starting after the last grant
   always_comb begin
      int c;
      next_idx = grant_q;
      found    = 1'b0;
      for (int i = 1; i <= N_PORTS; i++) begin
         c = int'(grant_q) + i;
         if (c >= N_PORTS) begin
            c = c - N_PORTS;
         end
         if (!found && m_req_i[c].req) begin
            found    = 1'b1;
            next_idx = c[SEL_W-1:0];
         end
      end
   end

   assign sel_idx   = busy_q ? grant_q : next_idx;
   assign sel_valid = busy_q || found;

   always_comb begin
      sel_req     = m_req_i[sel_idx];
      sel_req.req = sel_valid && m_req_i[sel_idx].req;
   end

   assign s_req_o = sel_req; // No added latency

   // Ack goes to the granted port only
   always_comb begin
      for (int p = 0; p < N_PORTS; p++) begin
         m_resp_o[p].rdata = s_resp_i.rdata;
         m_resp_o[p].ack   = s_resp_i.ack && sel_valid && (sel_idx == SEL_W'(p));
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         grant_q <= '0;
         busy_q  <= 1'b0;
      end else if (!busy_q && found) begin
         grant_q <= next_idx;
         busy_q  <= !s_resp_i.ack; // Same-cycle ack needs no lock
      end else if (busy_q && s_resp_i.ack) begin
         busy_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "ext_mem_consts.svh"

module l1_cache (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  ext_mem_pkg::nat_req_t  req_i,
   output ext_mem_pkg::nat_resp_t resp_o,
   input  logic                  invalidate_i,
   output ext_mem_pkg::nat_req_t  be_req_o,
   input  ext_mem_pkg::nat_resp_t be_resp_i
);

   import ext_mem_pkg::*;

   localparam int N_LINES = 1 << `EM_IDX_W;

   cache_state_t state_q, state_d;

   logic [N_LINES-1:0] valid_q;
   tag_t               tag_mem [N_LINES];
   data_t              data_mem [N_LINES];

   logic  ack_q;      // Front ack after a back-end access
   data_t rdata_q;
   logic  inv_pend_q; // Strobe seen while busy
   idx_t  inv_idx_q;

   idx_t  line_idx;
   tag_t  line_tag;
   data_t line_data;
   logic  is_rd;
   logic  hit;
   logic  be_done;

   // Fields are held stable by the master until ack
   assign line_idx  = req_i.addr[`EM_IDX_W-1:0];
   assign line_tag  = req_i.addr[`EM_ADDR_W-1:`EM_IDX_W];
   assign line_data = data_mem[line_idx];
   assign is_rd     = (req_i.wstrb == '0);
   assign hit       = valid_q[line_idx] && (tag_mem[line_idx] == line_tag);
   assign be_done   = ((state_q == MISS_RD) || (state_q == WR_THRU)) && be_resp_i.ack;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // Invalidation wins over a new request
            if (invalidate_i || inv_pend_q) begin
               state_d = INVAL;
            end else if (req_i.req && !ack_q) begin
               state_d = LOOKUP;
            end
         end
         LOOKUP: begin
            if (!is_rd) begin
               state_d = WR_THRU;
            end else if (!hit) begin
               state_d = MISS_RD;
            end else begin
               state_d = IDLE; // Hit acked here
            end
         end
         MISS_RD, WR_THRU: begin
            if (be_resp_i.ack) begin
               state_d = IDLE;
            end
         end
         INVAL: begin
            if (inv_idx_q == '1) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q    <= IDLE;
         ack_q      <= 1'b0;
         inv_pend_q <= 1'b0;
         inv_idx_q  <= '0;
         valid_q    <= '0;
      end else begin
         state_q <= state_d;
         ack_q   <= be_done;

         if ((state_q == IDLE) && (state_d == INVAL)) begin
            inv_pend_q <= 1'b0;
         end else if (invalidate_i) begin
            inv_pend_q <= 1'b1;
         end

         // Sweep one line per cycle, wraps back to zero
         if (state_q == INVAL) begin
            inv_idx_q          <= inv_idx_q + 1'b1;
            valid_q[inv_idx_q] <= 1'b0;
         end else if ((state_q == MISS_RD) && be_resp_i.ack) begin
            valid_q[line_idx] <= 1'b1;
         end
      end
   end

   // Line fill and write-hit merge
   always_ff @(posedge clk_i) begin
      if ((state_q == MISS_RD) && be_resp_i.ack) begin
         tag_mem[line_idx]  <= line_tag;
         data_mem[line_idx] <= be_resp_i.rdata;
      end else if ((state_q == WR_THRU) && be_resp_i.ack && hit) begin
         for (int b = 0; b < `EM_STRB_W; b++) begin
            if (req_i.wstrb[b]) begin
               data_mem[line_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
      end
      if (be_done) begin
         rdata_q <= be_resp_i.rdata;
      end
   end

   always_comb begin
      resp_o.ack   = ((state_q == LOOKUP) && is_rd && hit) || ack_q;
      resp_o.rdata = (state_q == LOOKUP) ? line_data : rdata_q;
   end

   // Write-through, no allocate on write
   always_comb begin
      be_req_o.req   = (state_q == MISS_RD) || (state_q == WR_THRU);
      be_req_o.addr  = req_i.addr;
      be_req_o.wdata = req_i.wdata;
      be_req_o.wstrb = (state_q == WR_THRU) ? req_i.wstrb : '0;
   end

endmodule

`default_nettype wire

// File: verilog/ext_mem_pkg.sv
`default_nettype none

`include "ext_mem_consts.svh"

package ext_mem_pkg;

   typedef logic [`EM_ADDR_W-1:0]           addr_t;
   typedef logic [`EM_DATA_W-1:0]           data_t;
   typedef logic [`EM_STRB_W-1:0]           strb_t; // Zero on a read
   typedef logic [`EM_IDX_W-1:0]            idx_t;
   typedef logic [`EM_ADDR_W-`EM_IDX_W-1:0] tag_t;  // Address bits above the index

   // Request side of the native bus
   typedef struct packed {
      logic  req;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } nat_req_t;

   typedef struct packed {
      data_t rdata;
      logic  ack;  // One-cycle pulse
   } nat_resp_t;

   typedef enum logic [2:0] {IDLE, LOOKUP, MISS_RD, WR_THRU, INVAL} cache_state_t;

endpackage

`default_nettype wire

// File: verilog/ext_mem_consts.svh
`ifndef EXT_MEM_CONSTS_SVH
`define EXT_MEM_CONSTS_SVH

// Native bus widths, addresses count 32-bit words
`define EM_ADDR_W 16
`define EM_DATA_W 32
`define EM_STRB_W 4

// Instruction and data port
`define EM_NPORTS 2

// 64 lines per L1
`define EM_IDX_W 6

`endif
